// File: src/intr_params.svh
// Interrupt and GPIO handler widths and counts fixed by the host register map
`ifndef INTR_PARAMS_SVH
`define INTR_PARAMS_SVH

// Device-to-host interrupt lines
`define INTR_C2H_W 64

// Host-to-device interrupt word of four 32-bit registers
`define INTR_H2C_W 128

// Each GPIO direction
`define GPIO_W 64

// Error status and error enable registers
`define ERR_W 32

// FIFO fill level registers and how many FIFOs are watched
`define FIFO_LVL_W 32
`define NUM_FIFOS 4

`endif

// File: src/intr_pkg.sv
// Interrupt and GPIO handler types shared by the RTL blocks
`include "intr_params.svh"

package intr_pkg;

   typedef logic [`INTR_C2H_W-1:0] c2h_intr_t;  // One bit per c2h line
   typedef logic [`INTR_H2C_W-1:0] h2c_intr_t;
   typedef logic [`GPIO_W-1:0]     gpio_t;
   typedef logic [`ERR_W-1:0]      err_t;       // Error status or enable
   typedef logic [`FIFO_LVL_W-1:0] fifo_lvl_t;

   // Bit order from LSB is rd_req, wr_req, sn_resp, sn_data
   typedef logic [`NUM_FIFOS-1:0]  fifo_en_t;

   // Acknowledge handshake with the host
   typedef enum logic [1:0] {
      IRQ_IDLE     = 2'b00,
      IRQ_ASSERT   = 2'b01,
      IRQ_ACKED    = 2'b10,
      IRQ_DEASSERT = 2'b11
   } irq_state_t;

endpackage

// File: src/c2h_intr_monitor.sv
// c2h interrupt monitor that mirrors the lines and keeps a sticky toggle bit per line
`timescale 1ns/1ps

module c2h_intr_monitor
(
   input  logic                clk,
   input  logic                resetn,
   input  intr_pkg::c2h_intr_t c2h_intr_in,
   input  intr_pkg::c2h_intr_t toggle_clear,
   output intr_pkg::c2h_intr_t intr_status,
   output intr_pkg::c2h_intr_t toggle_status
);

   import intr_pkg::*;

   c2h_intr_t c2h_prev;     // Lines as sampled on the last edge
   c2h_intr_t c2h_edge;     // Either edge on a line
   c2h_intr_t toggle_next;

   // Previous sample doubles as the status mirror
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         c2h_prev <= '0;    // First change after reset is seen as an edge
      end
      else
      begin
         c2h_prev <= c2h_intr_in;
      end
   end

   assign intr_status = c2h_prev;

   // Rising or falling both count
   assign c2h_edge = c2h_intr_in ^ c2h_prev;

   // A low bit sets on an edge and ignores clear
   // A high bit holds until the host clears it
   assign toggle_next = (~toggle_status & c2h_edge)
                      | (toggle_status & ~toggle_clear);

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         toggle_status <= '0;
      end
      else
      begin
         toggle_status <= toggle_next;
      end
   end

   // A toggle bit only rises where the line differed from its previous sample
   a_toggle_needs_edge : assert property (
      @(posedge clk) disable iff (!resetn)
      $past(resetn) |->
         ((toggle_status & ~$past(toggle_status)
           & ~$past(c2h_intr_in ^ c2h_prev)) == '0)
   )
   else $error("toggle bit set without a line change");

endmodule

// File: src/host_io_regs.sv
// Host I/O registers that sample c2h GPIO, register h2c interrupts and pass h2c GPIO
`timescale 1ns/1ps

module host_io_regs
(
   input  logic                clk,
   input  logic                resetn,
   input  intr_pkg::gpio_t     c2h_gpio_in,
   input  intr_pkg::gpio_t     h2c_gpio_in,
   input  intr_pkg::h2c_intr_t h2c_intr_in,
   output intr_pkg::gpio_t     c2h_gpio_status,
   output intr_pkg::gpio_t     h2c_gpio_out,
   output intr_pkg::h2c_intr_t h2c_intr_out
);

   // Device GPIO into the host status word
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         c2h_gpio_status <= '0;
      end
      else
      begin
         c2h_gpio_status <= c2h_gpio_in;
      end
   end

   // Host interrupt word toward the device one cycle behind the register bank
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         h2c_intr_out <= '0;
      end
      else
      begin
         h2c_intr_out <= h2c_intr_in;
      end
   end

   // h2c GPIO is already a register in the bank, so no extra stage
   assign h2c_gpio_out = h2c_gpio_in;

endmodule

// File: src/irq_ctrl.sv
// IRQ controller that merges enabled sources into one request with an ack handshake
`timescale 1ns/1ps

module irq_ctrl
(
   input  logic                clk,
   input  logic                resetn,
   input  intr_pkg::c2h_intr_t toggle_status,
   input  intr_pkg::c2h_intr_t toggle_enable,
   input  intr_pkg::err_t      err_status,
   input  intr_pkg::err_t      err_enable,
   input  intr_pkg::fifo_lvl_t rd_req_lvl,
   input  intr_pkg::fifo_lvl_t wr_req_lvl,
   input  intr_pkg::fifo_lvl_t sn_resp_lvl,
   input  intr_pkg::fifo_lvl_t sn_data_lvl,
   input  intr_pkg::fifo_en_t  fifo_enable,
   input  logic                irq_ack,
   output logic                irq_out
);

   import intr_pkg::*;

   fifo_en_t   fifo_nonempty;
   logic       pending;
   irq_state_t state;
   irq_state_t state_next;

   // Same bit order as fifo_enable
   assign fifo_nonempty = {|sn_data_lvl, |sn_resp_lvl, |wr_req_lvl, |rd_req_lvl};

   assign pending = (|(toggle_status & toggle_enable))
                  | (|(err_status & err_enable))
                  | (|(fifo_nonempty & fifo_enable));

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         state <= IRQ_IDLE;
      end
      else
      begin
         state <= state_next;
      end
   end

   always_comb
   begin
      state_next = state;
      case (state)
         IRQ_IDLE:
         begin
            if (pending)
               state_next = IRQ_ASSERT;
         end
         IRQ_ASSERT:
         begin
            if (irq_ack)
               state_next = IRQ_ACKED;   // Host has seen the request
         end
         IRQ_ACKED:
         begin
            if (!pending)
               state_next = IRQ_DEASSERT;  // Sources serviced
         end
         IRQ_DEASSERT:
         begin
            if (irq_ack)
               state_next = IRQ_IDLE;
         end
         default:
         begin
            state_next = IRQ_IDLE;
         end
      endcase
   end

   // Request stays up from assert until the sources are gone
   assign irq_out = (state == IRQ_ASSERT) || (state == IRQ_ACKED);

   a_irq_low_after_reset : assert property (
      @(posedge clk) !resetn |=> !irq_out
   )
   else $error("irq_out high in the cycle after reset");

   // No way out of ASSERT without the host ack
   a_assert_waits_ack : assert property (
      @(posedge clk) disable iff (!resetn)
      (state == IRQ_ASSERT) && !irq_ack |=> (state == IRQ_ASSERT)
   )
   else $error("left IRQ_ASSERT without irq_ack");

endmodule

// File: src/intr_top.sv
// Interrupt and GPIO handler top with the c2h monitor, host I/O registers and IRQ controller
`timescale 1ns/1ps

module intr_top
(
   input  logic                clk,
   input  logic                resetn,

   // Device interrupt lines and toggle control from the host
   input  intr_pkg::c2h_intr_t c2h_intr_in,
   input  intr_pkg::c2h_intr_t toggle_clear,
   input  intr_pkg::c2h_intr_t toggle_enable,

   // Error and FIFO sources
   input  intr_pkg::err_t      err_status,
   input  intr_pkg::err_t      err_enable,
   input  intr_pkg::fifo_lvl_t rd_req_lvl,
   input  intr_pkg::fifo_lvl_t wr_req_lvl,
   input  intr_pkg::fifo_lvl_t sn_resp_lvl,
   input  intr_pkg::fifo_lvl_t sn_data_lvl,
   input  intr_pkg::fifo_en_t  fifo_enable,

   // GPIO and h2c interrupt word
   input  intr_pkg::gpio_t     c2h_gpio_in,
   input  intr_pkg::gpio_t     h2c_gpio_in,
   input  intr_pkg::h2c_intr_t h2c_intr_in,

   input  logic                irq_ack,

   output intr_pkg::c2h_intr_t intr_status,
   output intr_pkg::c2h_intr_t toggle_status,  // Also a source for the request
   output intr_pkg::gpio_t     c2h_gpio_status,
   output intr_pkg::gpio_t     h2c_gpio_out,
   output intr_pkg::h2c_intr_t h2c_intr_out,
   output logic                irq_out
);

   c2h_intr_monitor i_c2h_intr_monitor
   (
      .clk           (clk),
      .resetn        (resetn),
      .c2h_intr_in   (c2h_intr_in),
      .toggle_clear  (toggle_clear),
      .intr_status   (intr_status),
      .toggle_status (toggle_status)
   );

   host_io_regs i_host_io_regs
   (
      .clk             (clk),
      .resetn          (resetn),
      .c2h_gpio_in     (c2h_gpio_in),
      .h2c_gpio_in     (h2c_gpio_in),
      .h2c_intr_in     (h2c_intr_in),
      .c2h_gpio_status (c2h_gpio_status),
      .h2c_gpio_out    (h2c_gpio_out),
      .h2c_intr_out    (h2c_intr_out)
   );

   // Toggle source is the monitor's own register
   irq_ctrl i_irq_ctrl
   (
      .clk           (clk),
      .resetn        (resetn),
      .toggle_status (toggle_status),
      .toggle_enable (toggle_enable),
      .err_status    (err_status),
      .err_enable    (err_enable),
      .rd_req_lvl    (rd_req_lvl),
      .wr_req_lvl    (wr_req_lvl),
      .sn_resp_lvl   (sn_resp_lvl),
      .sn_data_lvl   (sn_data_lvl),
      .fifo_enable   (fifo_enable),
      .irq_ack       (irq_ack),
      .irq_out       (irq_out)
   );

endmodule

// File: sim/tb_intr_top.sv
// Directed testbench for the interrupt and GPIO handler top level
`timescale 1ns/1ps

module tb_intr_top;

   import intr_pkg::*;

   logic      clk;
   logic      resetn;
   c2h_intr_t c2h_intr_in;
   c2h_intr_t toggle_clear;
   c2h_intr_t toggle_enable;
   err_t      err_status;
   err_t      err_enable;
   fifo_lvl_t rd_req_lvl;
   fifo_lvl_t wr_req_lvl;
   fifo_lvl_t sn_resp_lvl;
   fifo_lvl_t sn_data_lvl;
   fifo_en_t  fifo_enable;
   gpio_t     c2h_gpio_in;
   gpio_t     h2c_gpio_in;
   h2c_intr_t h2c_intr_in;
   logic      irq_ack;
   c2h_intr_t intr_status;
   c2h_intr_t toggle_status;
   gpio_t     c2h_gpio_status;
   gpio_t     h2c_gpio_out;
   h2c_intr_t h2c_intr_out;
   logic      irq_out;

   int          err_count;
   int          check_count;
   logic [31:0] lfsr;

   intr_top i_intr_top
   (
      .clk             (clk),
      .resetn          (resetn),
      .c2h_intr_in     (c2h_intr_in),
      .toggle_clear    (toggle_clear),
      .toggle_enable   (toggle_enable),
      .err_status      (err_status),
      .err_enable      (err_enable),
      .rd_req_lvl      (rd_req_lvl),
      .wr_req_lvl      (wr_req_lvl),
      .sn_resp_lvl     (sn_resp_lvl),
      .sn_data_lvl     (sn_data_lvl),
      .fifo_enable     (fifo_enable),
      .c2h_gpio_in     (c2h_gpio_in),
      .h2c_gpio_in     (h2c_gpio_in),
      .h2c_intr_in     (h2c_intr_in),
      .irq_ack         (irq_ack),
      .intr_status     (intr_status),
      .toggle_status   (toggle_status),
      .c2h_gpio_status (c2h_gpio_status),
      .h2c_gpio_out    (h2c_gpio_out),
      .h2c_intr_out    (h2c_intr_out),
      .irq_out         (irq_out)
   );

   always #20 clk = ~clk;   // 40 ns period

   // Galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic random_bits(input int n, output logic [127:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v[i] = lfsr[0];   // One step per bit
      end
   endtask

   task automatic check_c2h(input string name, input c2h_intr_t got, input c2h_intr_t exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_h2c(input string name, input h2c_intr_t got, input h2c_intr_t exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Polled on falling edges away from the DUT's updates
   task automatic wait_irq(input logic level, input int max_cycles);
      int n;
      n = 0;
      while (irq_out !== level && n < max_cycles)
      begin
         @(negedge clk);
         n++;
      end
      if (irq_out !== level)
      begin
         err_count++;
         $display("Timed out after %0d cycles waiting for irq_out to become %0d",
                  max_cycles, level);
      end
   endtask

   task automatic expect_irq_steady(input logic level, input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         check_bit("irq_out", irq_out, level);
      end
   endtask

   task automatic ack_pulse();
      irq_ack = 1'b1;
      @(negedge clk);
      irq_ack = 1'b0;
   endtask

   // Second cycle has no edges left, so every bit ends low
   task automatic clear_all_toggles();
      toggle_clear = '1;
      repeat (2) @(negedge clk);
      toggle_clear = '0;
      check_c2h("toggle_status", toggle_status, '0);
   endtask

   task automatic set_fifo_lvl(input int f, input fifo_lvl_t v);
      case (f)
         0: rd_req_lvl = v;
         1: wr_req_lvl = v;
         2: sn_resp_lvl = v;
         default: sn_data_lvl = v;
      endcase
   endtask

   task automatic test_reset();
      // Busy lines and a pending error source while resetn is low
      c2h_intr_in = '1;
      c2h_gpio_in = '1;
      h2c_intr_in = '1;
      err_status = '1;
      err_enable = '1;
      repeat (4) @(negedge clk);
      check_c2h("intr_status", intr_status, '0);
      check_c2h("toggle_status", toggle_status, '0);
      check_gpio("c2h_gpio_status", c2h_gpio_status, '0);
      check_h2c("h2c_intr_out", h2c_intr_out, '0);
      check_bit("irq_out", irq_out, 1'b0);
      c2h_intr_in = '0;
      c2h_gpio_in = '0;
      h2c_intr_in = '0;
      err_status = '0;
      err_enable = '0;
      resetn = 1'b1;
      @(negedge clk);
      // Previous sample starts at 0, so lines held low show no edge
      check_c2h("toggle_status", toggle_status, '0);
      check_bit("irq_out", irq_out, 1'b0);
   endtask

   task automatic test_mirror();
      logic [127:0] r;
      c2h_intr_t    c2h_v;
      gpio_t        cgpio_v;
      gpio_t        hgpio_v;
      h2c_intr_t    h2c_v;
      repeat (3)
      begin
         random_bits(64, r);
         c2h_v = r[63:0];
         random_bits(64, r);
         cgpio_v = r[63:0];
         random_bits(64, r);
         hgpio_v = r[63:0];
         random_bits(128, r);
         h2c_v = r;
         c2h_intr_in = c2h_v;
         c2h_gpio_in = cgpio_v;
         h2c_gpio_in = hgpio_v;
         h2c_intr_in = h2c_v;
         #1 check_gpio("h2c_gpio_out", h2c_gpio_out, hgpio_v);   // No register stage
         @(negedge clk);
         check_c2h("intr_status", intr_status, c2h_v);
         check_gpio("c2h_gpio_status", c2h_gpio_status, cgpio_v);
         check_h2c("h2c_intr_out", h2c_intr_out, h2c_v);
      end
      c2h_intr_in = '0;
      clear_all_toggles();
   endtask

   task automatic test_toggle();
      logic [127:0] r;
      c2h_intr_t    sel;
      c2h_intr_t    clr;
      random_bits(64, r);
      sel = r[63:0] | 64'h8000_0000_0000_0001;
      random_bits(64, r);
      clr = ((sel & r[63:0]) | 64'h1) & ~64'h8000_0000_0000_0000;   // Bit 63 never cleared
      c2h_intr_in = c2h_intr_in ^ sel;
      @(negedge clk);
      check_c2h("toggle_status", toggle_status, sel);
      check_c2h("intr_status", intr_status, sel);
      c2h_intr_in = c2h_intr_in ^ sel;   // Second edge on a set bit
      @(negedge clk);
      check_c2h("toggle_status", toggle_status, sel);
      toggle_clear = clr;
      @(negedge clk);
      toggle_clear = '0;
      check_c2h("toggle_status", toggle_status, sel & ~clr);
      @(negedge clk);
      check_c2h("toggle_status", toggle_status, sel & ~clr);
      check_bit("irq_out", irq_out, 1'b0);   // All toggle enables are 0
      // New edge wins over clear on a low bit
      toggle_clear = clr;
      c2h_intr_in = c2h_intr_in ^ clr;
      @(negedge clk);
      check_c2h("toggle_status", toggle_status, sel);
      @(negedge clk);
      check_c2h("toggle_status", toggle_status, sel & ~clr);
      toggle_clear = '0;
      c2h_intr_in = '0;
      clear_all_toggles();
   endtask

   task automatic test_irq_toggle();
      logic [127:0] r;
      c2h_intr_t    bit_m;
      random_bits(6, r);
      bit_m = '0;
      bit_m[r[5:0]] = 1'b1;
      toggle_enable = bit_m;
      c2h_intr_in = c2h_intr_in ^ bit_m;
      wait_irq(1'b1, 8);
      expect_irq_steady(1'b1, 3);   // Held until the host acks
      ack_pulse();
      check_bit("irq_out", irq_out, 1'b1);
      toggle_clear = bit_m;
      @(negedge clk);
      toggle_clear = '0;
      wait_irq(1'b0, 8);
      // Pending again, but the FSM waits for the second ack
      c2h_intr_in = c2h_intr_in ^ bit_m;
      expect_irq_steady(1'b0, 3);
      ack_pulse();
      wait_irq(1'b1, 8);
      ack_pulse();
      toggle_clear = bit_m;
      @(negedge clk);
      toggle_clear = '0;
      wait_irq(1'b0, 8);
      ack_pulse();
      expect_irq_steady(1'b0, 2);
      toggle_enable = '0;
      c2h_intr_in = '0;
      clear_all_toggles();
   endtask

   task automatic test_irq_sources();
      logic [127:0] r;
      fifo_lvl_t    lvl;
      random_bits(5, r);
      err_status = '0;
      err_status[r[4:0]] = 1'b1;
      err_enable = ~err_status;
      expect_irq_steady(1'b0, 3);
      err_enable = err_status;
      wait_irq(1'b1, 8);
      ack_pulse();
      err_status = '0;
      wait_irq(1'b0, 8);
      ack_pulse();
      err_enable = '0;
      for (int f = 0; f < 4; f++)
      begin
         random_bits(32, r);
         lvl = r[31:0] | 32'h1;
         set_fifo_lvl(f, lvl);
         fifo_enable = ~(fifo_en_t'(1) << f);   // Other FIFOs are empty
         expect_irq_steady(1'b0, 3);
         fifo_enable = fifo_en_t'(1) << f;
         wait_irq(1'b1, 8);
         ack_pulse();
         set_fifo_lvl(f, '0);
         wait_irq(1'b0, 8);
         ack_pulse();
         fifo_enable = '0;
      end
      expect_irq_steady(1'b0, 2);
   endtask

   initial
   begin
      repeat (4000) @(posedge clk);
      $display("Simulation did not finish within 4000 cycles");
      $display("Checks failed");
      $finish;
   end

   initial
   begin
      clk = 1'b0;
      resetn = 1'b0;
      c2h_intr_in = '0;
      toggle_clear = '0;
      toggle_enable = '0;
      err_status = '0;
      err_enable = '0;
      rd_req_lvl = '0;
      wr_req_lvl = '0;
      sn_resp_lvl = '0;
      sn_data_lvl = '0;
      fifo_enable = '0;
      c2h_gpio_in = '0;
      h2c_gpio_in = '0;
      h2c_intr_in = '0;
      irq_ack = 1'b0;
      err_count = 0;
      check_count = 0;
      lfsr = 32'h869a_2cd5;
      test_reset();
      test_mirror();
      test_toggle();
      test_irq_toggle();
      test_irq_sources();
      $display("Checks run: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: compile.f
+incdir+src
src/intr_pkg.sv
src/c2h_intr_monitor.sv
src/host_io_regs.sv
src/irq_ctrl.sv
src/intr_top.sv
sim/tb_intr_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f compile.f --top-module tb_intr_top -Mdir obj_dir || exit 1

out=$(./obj_dir/Vtb_intr_top)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All checks passed" && exit 0 || exit 1
